// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = src.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== hdl/core_pkg.sv ====
package core_pkg;

  // Widths and counts
  localparam int inst_width     = 16;
  localparam int data_width     = 32;
  localparam int addr_width     = 32;
  localparam int num_regs       = 16;
  localparam int reg_addr_width = 4;
  localparam int opcode_width   = 4;
  localparam int literal_width  = 8;

  // Register-form ALU operations, rd = rd op rn
  localparam logic [opcode_width-1:0] op_add  = 4'h0;
  localparam logic [opcode_width-1:0] op_sub  = 4'h1;
  localparam logic [opcode_width-1:0] op_and  = 4'h2;
  localparam logic [opcode_width-1:0] op_or   = 4'h3;
  localparam logic [opcode_width-1:0] op_xor  = 4'h4;
  localparam logic [opcode_width-1:0] op_shl  = 4'h5;
  localparam logic [opcode_width-1:0] op_shr  = 4'h6;
  localparam logic [opcode_width-1:0] op_mov  = 4'h7;

  // Literal forms
  localparam logic [opcode_width-1:0] op_ldi  = 4'h8;
  localparam logic [opcode_width-1:0] op_addi = 4'h9;

  // Store rd value to address held in rn
  localparam logic [opcode_width-1:0] op_str  = 4'ha;

  // Remaining codes decode as no-ops

  typedef struct packed {
    logic [opcode_width-1:0]   opcode;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rn;
    logic [3:0]                unused;
  } reg_form_t;

  typedef struct packed {
    logic [opcode_width-1:0]   opcode;
    logic [reg_addr_width-1:0] rd;
    logic [literal_width-1:0]  literal;
  } lit_form_t;

  // One instruction word, two readings
  typedef union packed {
    reg_form_t reg_view;
    lit_form_t lit_view;
  } instr_u;

endpackage

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic                  core_clk,
  input  logic                  reset_i,

  // Instruction port
  output logic [addr_width-1:0] inst_addr_o,
  output logic                  inst_valid_o,
  input  logic [inst_width-1:0] inst_data_i,
  input  logic                  inst_valid_i,

  // Data port, stores only
  output logic [addr_width-1:0] mem_addr_o,
  output logic [data_width-1:0] mem_data_o,
  output logic                  mem_write_o
);

  logic [inst_width-1:0]     instr_data;
  logic                      instr_valid;

  logic                      dec_valid;
  logic [opcode_width-1:0]   dec_op;
  logic [reg_addr_width-1:0] dec_rd;
  logic [reg_addr_width-1:0] dec_rn;
  logic [data_width-1:0]     dec_literal;
  logic                      dec_use_lit;
  logic                      dec_reg_write;
  logic                      dec_is_store;

  logic                      ex_valid;
  logic [opcode_width-1:0]   ex_op;
  logic [reg_addr_width-1:0] ex_rd_addr;
  logic [data_width-1:0]     ex_a;
  logic [data_width-1:0]     ex_b;
  logic                      ex_reg_write;
  logic                      ex_is_store;

  logic                      wb_en;
  logic [reg_addr_width-1:0] wb_addr;
  logic [data_width-1:0]     wb_data;

  inst_fetch inst_fetch_i (
    .core_clk      (core_clk),
    .reset_i       (reset_i),
    .inst_addr_o   (inst_addr_o),
    .inst_valid_o  (inst_valid_o),
    .inst_data_i   (inst_data_i),
    .inst_valid_i  (inst_valid_i),
    .instr_data_o  (instr_data),
    .instr_valid_o (instr_valid)
  );

  inst_decode inst_decode_i (
    .core_clk        (core_clk),
    .reset_i         (reset_i),
    .instr_data_i    (instr_data),
    .instr_valid_i   (instr_valid),
    .dec_valid_o     (dec_valid),
    .dec_op_o        (dec_op),
    .dec_rd_o        (dec_rd),
    .dec_rn_o        (dec_rn),
    .dec_literal_o   (dec_literal),
    .dec_use_lit_o   (dec_use_lit),
    .dec_reg_write_o (dec_reg_write),
    .dec_is_store_o  (dec_is_store)
  );

  register_file register_file_i (
    .core_clk        (core_clk),
    .reset_i         (reset_i),
    .dec_valid_i     (dec_valid),
    .dec_op_i        (dec_op),
    .dec_rd_i        (dec_rd),
    .dec_rn_i        (dec_rn),
    .dec_literal_i   (dec_literal),
    .dec_use_lit_i   (dec_use_lit),
    .dec_reg_write_i (dec_reg_write),
    .dec_is_store_i  (dec_is_store),
    .wb_en_i         (wb_en),
    .wb_addr_i       (wb_addr),
    .wb_data_i       (wb_data),
    .ex_valid_o      (ex_valid),
    .ex_op_o         (ex_op),
    .ex_rd_addr_o    (ex_rd_addr),
    .ex_a_o          (ex_a),
    .ex_b_o          (ex_b),
    .ex_reg_write_o  (ex_reg_write),
    .ex_is_store_o   (ex_is_store)
  );

  execute_unit execute_unit_i (
    .core_clk       (core_clk),
    .reset_i        (reset_i),
    .ex_valid_i     (ex_valid),
    .ex_op_i        (ex_op),
    .ex_rd_addr_i   (ex_rd_addr),
    .ex_a_i         (ex_a),
    .ex_b_i         (ex_b),
    .ex_reg_write_i (ex_reg_write),
    .ex_is_store_i  (ex_is_store),
    .wb_en_o        (wb_en),
    .wb_addr_o      (wb_addr),
    .wb_data_o      (wb_data),
    .mem_addr_o     (mem_addr_o),
    .mem_data_o     (mem_data_o),
    .mem_write_o    (mem_write_o)
  );

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
  input  logic                      core_clk,
  input  logic                      reset_i,

  input  logic                      ex_valid_i,
  input  logic [opcode_width-1:0]   ex_op_i,
  input  logic [reg_addr_width-1:0] ex_rd_addr_i,
  input  logic [data_width-1:0]     ex_a_i,
  input  logic [data_width-1:0]     ex_b_i,
  input  logic                      ex_reg_write_i,
  input  logic                      ex_is_store_i,

  output logic                      wb_en_o,
  output logic [reg_addr_width-1:0] wb_addr_o,
  output logic [data_width-1:0]     wb_data_o,

  output logic [addr_width-1:0]     mem_addr_o,
  output logic [data_width-1:0]     mem_data_o,
  output logic                      mem_write_o
);

  logic [data_width-1:0] alu_result;
  logic [4:0]            shamt;

  // Shift amount from the low bits of rn
  assign shamt = ex_b_i[4:0];

  always_comb
  begin
    case (ex_op_i)
      op_add:  alu_result = ex_a_i + ex_b_i;
      op_sub:  alu_result = ex_a_i - ex_b_i;
      op_and:  alu_result = ex_a_i & ex_b_i;
      op_or:   alu_result = ex_a_i | ex_b_i;
      op_xor:  alu_result = ex_a_i ^ ex_b_i;
      op_shl:  alu_result = ex_a_i << shamt;
      op_shr:  alu_result = ex_a_i >> shamt;
      op_mov:  alu_result = ex_b_i;
      op_ldi:  alu_result = ex_b_i;
      op_addi: alu_result = ex_a_i + ex_b_i;
      default: alu_result = ex_a_i;
    endcase
  end

  // Write-back steers the register file straight from the operand registers,
  // so the array updates on the edge after operand fetch
  assign wb_en_o   = ex_valid_i && ex_reg_write_i;
  assign wb_addr_o = ex_rd_addr_i;
  assign wb_data_o = alu_result;

  // Store strobe
  always_ff @(posedge core_clk)
  begin
    if (reset_i)
      mem_write_o <= 1'b0;
    else
      mem_write_o <= ex_valid_i && ex_is_store_i;
  end

  // rd value goes to the address held in rn
  always_ff @(posedge core_clk)
  begin
    if (ex_valid_i && ex_is_store_i)
    begin
      mem_addr_o <= addr_width'(ex_b_i);
      mem_data_o <= ex_a_i;
    end
  end

  // A store never writes a register, and stages are spaced apart
  a_wb_store_exclusive : assert property (
    @(posedge core_clk) disable iff (reset_i)
    !(wb_en_o && mem_write_o)
  ) else $error("write-back and store strobe high together");

endmodule

// ==== hdl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode import core_pkg::*; (
  input  logic                      core_clk,
  input  logic                      reset_i,

  input  instr_u                    instr_data_i,
  input  logic                      instr_valid_i,

  output logic                      dec_valid_o,
  output logic [opcode_width-1:0]   dec_op_o,
  output logic [reg_addr_width-1:0] dec_rd_o,
  output logic [reg_addr_width-1:0] dec_rn_o,
  output logic [data_width-1:0]     dec_literal_o,
  output logic                      dec_use_lit_o,
  output logic                      dec_reg_write_o,
  output logic                      dec_is_store_o
);

  logic [opcode_width-1:0]   op;
  logic [reg_addr_width-1:0] rd;
  logic [reg_addr_width-1:0] rn;
  logic [data_width-1:0]     literal;
  logic                      use_lit;
  logic                      reg_write;
  logic                      is_store;

  // Opcode occupies the same bits in both forms
  assign op = instr_data_i.reg_view.opcode;

  always_comb
  begin
    rd        = instr_data_i.reg_view.rd;
    rn        = instr_data_i.reg_view.rn;
    literal   = '0;
    use_lit   = 1'b0;
    reg_write = 1'b0;
    is_store  = 1'b0;
    case (op)
      op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr, op_mov:
        reg_write = 1'b1;
      op_ldi, op_addi:
      begin
        literal   = {{(data_width-literal_width){1'b0}}, instr_data_i.lit_view.literal};
        use_lit   = 1'b1;
        reg_write = 1'b1;
      end
      op_str:
        is_store = 1'b1;
      default:
        reg_write = 1'b0;
    endcase
  end

  always_ff @(posedge core_clk)
  begin
    if (reset_i)
    begin
      dec_valid_o     <= 1'b0;
      dec_reg_write_o <= 1'b0;
      dec_is_store_o  <= 1'b0;
    end
    else
    begin
      dec_valid_o <= instr_valid_i;
      if (instr_valid_i)
      begin
        dec_reg_write_o <= reg_write;
        dec_is_store_o  <= is_store;
      end
    end
  end

  // Payload only meaningful with dec_valid_o
  always_ff @(posedge core_clk)
  begin
    if (instr_valid_i)
    begin
      dec_op_o      <= op;
      dec_rd_o      <= rd;
      dec_rn_o      <= rn;
      dec_literal_o <= literal;
      dec_use_lit_o <= use_lit;
    end
  end

endmodule

// ==== hdl/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch import core_pkg::*; (
  input  logic                  core_clk,
  input  logic                  reset_i,

  output logic [addr_width-1:0] inst_addr_o,
  output logic                  inst_valid_o,
  input  logic [inst_width-1:0] inst_data_i,
  input  logic                  inst_valid_i,

  output logic [inst_width-1:0] instr_data_o,
  output logic                  instr_valid_o
);

  logic [addr_width-1:0] pc_q;
  logic                  pending_q;

  // One request in flight; a response immediately triggers the next one
  always_ff @(posedge core_clk)
  begin
    if (reset_i)
    begin
      pc_q         <= '0;
      pending_q    <= 1'b0;
      inst_valid_o <= 1'b0;
    end
    else
    begin
      inst_valid_o <= 1'b0;
      if (!pending_q || inst_valid_i)
      begin
        inst_valid_o <= 1'b1;
        pending_q    <= 1'b1;
      end
      if (inst_valid_i)
        pc_q <= pc_q + 1'b1;
    end
  end

  assign inst_addr_o = pc_q;

  // Response word goes straight to decode, which registers it
  assign instr_data_o  = inst_data_i;
  assign instr_valid_o = inst_valid_i && pending_q;

  // Responder must not answer a request that was never made
  a_resp_needs_req : assert property (
    @(posedge core_clk) disable iff (reset_i)
    inst_valid_i |-> pending_q
  ) else $error("instruction response without pending request");

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file import core_pkg::*; (
  input  logic                      core_clk,
  input  logic                      reset_i,

  input  logic                      dec_valid_i,
  input  logic [opcode_width-1:0]   dec_op_i,
  input  logic [reg_addr_width-1:0] dec_rd_i,
  input  logic [reg_addr_width-1:0] dec_rn_i,
  input  logic [data_width-1:0]     dec_literal_i,
  input  logic                      dec_use_lit_i,
  input  logic                      dec_reg_write_i,
  input  logic                      dec_is_store_i,

  input  logic                      wb_en_i,
  input  logic [reg_addr_width-1:0] wb_addr_i,
  input  logic [data_width-1:0]     wb_data_i,

  output logic                      ex_valid_o,
  output logic [opcode_width-1:0]   ex_op_o,
  output logic [reg_addr_width-1:0] ex_rd_addr_o,
  output logic [data_width-1:0]     ex_a_o,
  output logic [data_width-1:0]     ex_b_o,
  output logic                      ex_reg_write_o,
  output logic                      ex_is_store_o
);

  logic [data_width-1:0] regs_q [num_regs];

  always_ff @(posedge core_clk)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < num_regs; i++)
        regs_q[i] <= '0;
    end
    else if (wb_en_i)
      regs_q[wb_addr_i] <= wb_data_i;
  end

  // Operand fetch stage
  always_ff @(posedge core_clk)
  begin
    if (reset_i)
    begin
      ex_valid_o     <= 1'b0;
      ex_reg_write_o <= 1'b0;
      ex_is_store_o  <= 1'b0;
    end
    else
    begin
      ex_valid_o <= dec_valid_i;
      if (dec_valid_i)
      begin
        ex_reg_write_o <= dec_reg_write_i;
        ex_is_store_o  <= dec_is_store_i;
      end
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (dec_valid_i)
    begin
      ex_op_o      <= dec_op_i;
      ex_rd_addr_o <= dec_rd_i;
      ex_a_o       <= regs_q[dec_rd_i];
      // Second operand is either rn or the literal
      ex_b_o       <= dec_use_lit_i ? dec_literal_i : regs_q[dec_rn_i];
    end
  end

  // No forwarding path, so spacing of responses must keep these apart
  a_no_wb_read_clash : assert property (
    @(posedge core_clk) disable iff (reset_i)
    (wb_en_i && dec_valid_i) |->
      (wb_addr_i != dec_rd_i) && (dec_use_lit_i || wb_addr_i != dec_rn_i)
  ) else $error("write-back collides with operand read of r%0d", wb_addr_i);

endmodule

// ==== src.f ====
+incdir+tests
hdl/core_pkg.sv
hdl/inst_fetch.sv
hdl/inst_decode.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/core_top.sv
tests/core_tb.sv

// ==== tests/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

  // Architectural register state in program order
  logic [data_width-1:0] model_regs [num_regs];

  // Stores the model expects on the data port, oldest first
  logic [addr_width-1:0] exp_store_addr [$];
  logic [data_width-1:0] exp_store_data [$];
  int                    model_store_count;

  task automatic model_reset();
    for (int i = 0; i < num_regs; i++)
      model_regs[i] = '0;
    exp_store_addr.delete();
    exp_store_data.delete();
    model_store_count = 0;
  endtask

  // One instruction, applied the moment it is handed to the core
  task automatic model_apply(input instr_u w);
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rn;
    logic [data_width-1:0]     lit;
    rd  = w.reg_view.rd;
    rn  = w.reg_view.rn;
    lit = data_width'(w.lit_view.literal);
    case (w.reg_view.opcode)
      op_add:  model_regs[rd] = model_regs[rd] + model_regs[rn];
      op_sub:  model_regs[rd] = model_regs[rd] - model_regs[rn];
      op_and:  model_regs[rd] = model_regs[rd] & model_regs[rn];
      op_or:   model_regs[rd] = model_regs[rd] | model_regs[rn];
      op_xor:  model_regs[rd] = model_regs[rd] ^ model_regs[rn];
      op_shl:  model_regs[rd] = model_regs[rd] << model_regs[rn][4:0];
      op_shr:  model_regs[rd] = model_regs[rd] >> model_regs[rn][4:0];
      op_mov:  model_regs[rd] = model_regs[rn];
      op_ldi:  model_regs[rd] = lit;
      op_addi: model_regs[rd] = model_regs[rd] + lit;
      op_str:
      begin
        exp_store_addr.push_back(model_regs[rn]);
        exp_store_data.push_back(model_regs[rd]);
        model_store_count++;
      end
      default: ;
    endcase
  endtask

`endif

// ==== tests/core_tb.sv ====
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

  localparam int num_instr     = 400;
  localparam int reset_cycles  = 8;
  localparam int store_latency = 3;
  localparam int timeout_limit = num_instr * 6 + 100;

  logic                  core_clk = 1'b0;
  logic                  reset_i;
  logic [addr_width-1:0] inst_addr_o;
  logic                  inst_valid_o;
  logic [inst_width-1:0] inst_data_i;
  logic                  inst_valid_i;
  logic [addr_width-1:0] mem_addr_o;
  logic [data_width-1:0] mem_data_o;
  logic                  mem_write_o;

  logic [31:0] lfsr_state = 32'h1820_edef;
  instr_u      prog_words [num_instr];
  int          resp_delay [num_instr];
  logic [7:0]  first_lit_data;
  logic [7:0]  first_lit_addr;
  int          store_edge_q [$];
  int          edge_idx;
  int          timeout_cycles = 0;
  int          req_count;
  int          sent;
  int          store_count;
  int          resp_wait;
  int          last_resp_edge;
  logic        req_pending;

  `include "core_model.svh"

  core_top core_top_i (
    .core_clk     (core_clk),
    .reset_i      (reset_i),
    .inst_addr_o  (inst_addr_o),
    .inst_valid_o (inst_valid_o),
    .inst_data_i  (inst_data_i),
    .inst_valid_i (inst_valid_i),
    .mem_addr_o   (mem_addr_o),
    .mem_data_o   (mem_data_o),
    .mem_write_o  (mem_write_o)
  );

  always #5 core_clk = ~core_clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
  endtask

  // Right-shifting Galois form
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'ha300_0000;
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // Two ldi and a str of r1 to [r2] open the program before the random words
  task automatic build_program();
    instr_u                    w;
    logic [opcode_width-1:0]   op;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rn;
    logic [7:0]                lit;
    first_lit_data = 8'(take_bits(8));
    first_lit_addr = 8'(take_bits(8));
    for (int i = 0; i < num_instr; i++)
    begin
      op  = 4'(take_bits(4) % 11);
      rd  = {2'b00, 2'(take_bits(2))};
      rn  = {2'b00, 2'(take_bits(2))};
      lit = 8'(take_bits(8));
      if (i < 2)
      begin
        op  = op_ldi;
        rd  = (i == 0) ? 4'd1 : 4'd2;
        lit = (i == 0) ? first_lit_data : first_lit_addr;
      end
      else if (i == 2)
      begin
        op = op_str;
        rd = 4'd1;
        rn = 4'd2;
      end
      w = '0;
      if (op == op_ldi || op == op_addi)
      begin
        w.lit_view.opcode  = op;
        w.lit_view.rd      = rd;
        w.lit_view.literal = lit;
      end
      else
      begin
        w.reg_view.opcode = op;
        w.reg_view.rd     = rd;
        w.reg_view.rn     = rn;
      end
      prog_words[i] = w;
      resp_delay[i] = int'(take_bits(2)) + 1;
    end
  endtask

  task automatic check_idle();
    assert (inst_valid_o === 1'b0 && mem_write_o === 1'b0)
    else fail_run("request or store strobe active during or right after reset");
  endtask

  // Outputs sampled at the rising edge before any register update
  task automatic sample_outputs();
    if (inst_valid_i)
      req_pending = 1'b0;
    if (inst_valid_o)
    begin
      assert (!req_pending)
      else fail_run("instruction request issued while another was pending");
      check_value("fetch_addr", 32'(req_count), inst_addr_o);
      req_pending = 1'b1;
      if (req_count < num_instr)
        resp_wait = resp_delay[req_count];
      req_count++;
    end
    if (mem_write_o)
    begin
      assert (exp_store_addr.size() > 0)
      else fail_run("store strobe seen with no store expected by the model");
      check_value("store_addr", exp_store_addr.pop_front(), mem_addr_o);
      check_value("store_data", exp_store_data.pop_front(), mem_data_o);
      check_value("store_latency", 32'(store_edge_q.pop_front()), 32'(edge_idx));
      if (store_count == 0)
      begin
        check_value("ldi_str_literal", 32'(first_lit_data), mem_data_o);
        check_value("ldi_str_address", 32'(first_lit_addr), mem_addr_o);
      end
      store_count++;
    end
  endtask

  // Instruction memory responder
  task automatic drive_inputs();
    inst_valid_i = 1'b0;
    if (resp_wait > 0)
    begin
      resp_wait--;
      if (resp_wait == 0)
      begin
        inst_data_i  = prog_words[sent];
        inst_valid_i = 1'b1;
        model_apply(prog_words[sent]);
        if (prog_words[sent].reg_view.opcode == op_str)
          store_edge_q.push_back(edge_idx + 1 + store_latency);
        last_resp_edge = edge_idx + 1;
        sent++;
      end
    end
  endtask

  initial
  begin
    reset_i        = 1'b1;
    inst_valid_i   = 1'b0;
    inst_data_i    = '0;
    edge_idx       = 0;
    req_count      = 0;
    sent           = 0;
    store_count    = 0;
    resp_wait      = 0;
    last_resp_edge = 0;
    req_pending    = 1'b0;
    model_reset();
    build_program();

    repeat (reset_cycles)
    begin
      @(posedge core_clk);
      edge_idx++;
      if (edge_idx > 1)
        check_idle();
    end
    #1 reset_i = 1'b0;

    // Run until every instruction is sent and the last one has drained
    while (sent < num_instr || edge_idx < last_resp_edge + store_latency + 2)
    begin
      @(posedge core_clk);
      edge_idx++;
      if (edge_idx == reset_cycles + 1)
        check_idle();
      sample_outputs();
      #1;
      drive_inputs();
    end

    check_value("store_count", 32'(model_store_count), 32'(store_count));
    $display("** PASS **");
    $finish;
  end

  always @(posedge core_clk)
  begin
    timeout_cycles++;
    if (timeout_cycles > timeout_limit)
      fail_run("run did not finish within the cycle limit");
  end

endmodule
